// File: pipePkg.sv
package pipePkg;

    // word address width carried in a memory request
    localparam int WORD_ADDR_W = 10;

    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_BS   = 3'd1,
        LD_BU   = 3'd2,
        LD_HS   = 3'd3,
        LD_HU   = 3'd4,
        LD_W    = 3'd5
    } LoadType;

    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_B    = 2'd1,
        ST_H    = 2'd2,
        ST_W    = 2'd3
    } StoreType;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } WbSel;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ADEL = 2'd1,
        EXC_ADES = 2'd2
    } ExcCode;

    // executed instruction entering the memory stage
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        // also the data address
        logic [31:0] aluOut;
        logic [31:0] storeData;
        LoadType     loadType;
        StoreType    storeType;
        WbSel        wbSel;
        logic        regWrite;
        logic [4:0]  dst;
        ExcCode      exc;
    } ExeMemBundle;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] wbData;
        logic        regWrite;
        logic [4:0]  dst;
        ExcCode      exc;
    } MemWbBundle;

    typedef struct packed {
        logic [WORD_ADDR_W-1:0] wordAddr;
        logic [3:0]             byteEn;
        logic                   write;
        logic [31:0]            wdata;
    } MemReq;

endpackage

// File: pipeReg.sv
module pipeReg #(
    parameter type PAYLOAD_T = logic [31:0]
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     flush,
    input  logic     wr,
    input  PAYLOAD_T d,
    output PAYLOAD_T q
);

    // an all-zero payload is a bubble, valid low
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (flush) begin
            // flush wins over a write in the same cycle
            q <= '0;
        end else if (wr) begin
            q <= d;
        end
    end

endmodule

// File: storeAlign.sv
module storeAlign
    import pipePkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  ExeMemBundle ex,
    output MemReq       req,
    output logic        misaligned
);

    logic [1:0] addrLo;
    logic       isHalf;
    logic       isWord;

    assign addrLo = ex.aluOut[1:0];

    // access size, loads and stores alike
    assign isHalf = (ex.storeType == ST_H) || (ex.loadType == LD_HS) ||
                    (ex.loadType == LD_HU);
    assign isWord = (ex.storeType == ST_W) || (ex.loadType == LD_W);

    assign misaligned = ex.valid && ((isHalf && addrLo[0]) ||
                                     (isWord && (addrLo != 2'b00)));

    always_comb begin
        req.wordAddr = WORD_ADDR_W'(ex.aluOut[ADDR_W+1:2]);
        req.write    = (ex.storeType != ST_NONE);
        case (ex.storeType)
            ST_B: begin
                req.byteEn = 4'b0001 << addrLo;
                // byte copied into every lane, enables pick one
                req.wdata  = {4{ex.storeData[7:0]}};
            end
            ST_H: begin
                req.byteEn = addrLo[1] ? 4'b1100 : 4'b0011;
                req.wdata  = {2{ex.storeData[15:0]}};
            end
            ST_W: begin
                req.byteEn = 4'b1111;
                req.wdata  = ex.storeData;
            end
            default: begin
                req.byteEn = 4'b0000;
                req.wdata  = ex.storeData;
            end
        endcase
    end

endmodule

// File: dataMemPort.sv
module dataMemPort
    import pipePkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        start,
    input  logic        newEntry,
    input  MemReq       reqIn,
    output MemReq       memReq,
    output logic        req,
    input  logic        ack,
    input  logic [31:0] rdata,
    output logic [31:0] loadData,
    output logic        busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT_LOW,
        S_DONE
    } PortState;

    PortState state;
    MemReq    issueReq;
    logic     launch;

    // address bits beyond the RAM are dropped
    always_comb begin
        issueReq          = reqIn;
        issueReq.wordAddr = WORD_ADDR_W'(reqIn.wordAddr[ADDR_W-1:0]);
    end

    assign launch = (state == S_IDLE) && start;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) state <= S_REQ;
                end
                S_REQ: begin
                    if (ack) state <= S_WAIT_LOW;
                end
                S_WAIT_LOW: begin
                    if (!ack) state <= S_DONE;
                end
                // done flag, held until EX/MEM takes another entry
                S_DONE: begin
                    if (newEntry) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // request held steady for the whole handshake
    always_ff @(posedge clk) begin
        if (launch) begin
            memReq <= issueReq;
        end
        if ((state == S_REQ) && ack) begin
            loadData <= rdata;
        end
    end

    assign req  = (state == S_REQ);
    assign busy = launch || (state == S_REQ) || (state == S_WAIT_LOW);

endmodule

// File: dataRam.sv
module dataRam
    import pipePkg::*;
#(
    parameter int RAM_DEPTH_LOG2 = 8,
    parameter int RAM_LATENCY    = 2
) (
    input  logic        clk,
    input  logic        rstN,
    input  MemReq       memReq,
    input  logic        req,
    output logic        ack,
    output logic [31:0] rdata
);

    localparam int CNT_W = $clog2(RAM_LATENCY + 1);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(RAM_LATENCY - 1);

    typedef enum logic [1:0] {
        R_IDLE,
        R_DELAY,
        R_ACK
    } RamState;

    RamState                   state;
    logic [CNT_W-1:0]          cnt;
    logic                      doAccess;
    logic [RAM_DEPTH_LOG2-1:0] index;
    logic [31:0]               mem [2**RAM_DEPTH_LOG2];

    assign doAccess = (state == R_DELAY) && (cnt == LAST_CNT);
    assign index    = memReq.wordAddr[RAM_DEPTH_LOG2-1:0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= R_IDLE;
            cnt   <= '0;
            ack   <= 1'b0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (req) begin
                        cnt   <= '0;
                        state <= R_DELAY;
                    end
                end
                R_DELAY: begin
                    if (doAccess) begin
                        ack   <= 1'b1;
                        state <= R_ACK;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // ack stays up until the master lets go of req
                R_ACK: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**RAM_DEPTH_LOG2; i++) begin
                mem[i] <= '0;
            end
        end else if (doAccess && memReq.write) begin
            for (int b = 0; b < 4; b++) begin
                if (memReq.byteEn[b]) mem[index][8*b +: 8] <= memReq.wdata[8*b +: 8];
            end
        end
    end

    // read data valid together with ack
    always_ff @(posedge clk) begin
        if (doAccess) begin
            rdata <= mem[index];
        end
    end

endmodule

// File: loadExtract.sv
module loadExtract
    import pipePkg::*;
(
    input  ExeMemBundle ex,
    input  logic [31:0] loadData,
    input  logic        misaligned,
    output MemWbBundle  wb
);

    logic [1:0]  addrLo;
    logic [7:0]  laneByte;
    logic [15:0] laneHalf;
    logic [31:0] loadVal;

    assign addrLo   = ex.aluOut[1:0];
    assign laneByte = loadData[{addrLo, 3'b000} +: 8];
    assign laneHalf = addrLo[1] ? loadData[31:16] : loadData[15:0];

    always_comb begin
        case (ex.loadType)
            LD_BS:   loadVal = {{24{laneByte[7]}}, laneByte};
            LD_BU:   loadVal = {24'b0, laneByte};
            LD_HS:   loadVal = {{16{laneHalf[15]}}, laneHalf};
            LD_HU:   loadVal = {16'b0, laneHalf};
            default: loadVal = loadData;
        endcase
    end

    always_comb begin
        wb.valid    = ex.valid;
        wb.pc       = ex.pc;
        wb.wbData   = (ex.wbSel == WB_MEM) ? loadVal : ex.aluOut;
        wb.dst      = ex.dst;
        wb.regWrite = ex.regWrite;
        wb.exc      = ex.exc;
        // address error, register file left untouched
        if (misaligned) begin
            wb.regWrite = 1'b0;
            wb.exc      = (ex.storeType != ST_NONE) ? EXC_ADES : EXC_ADEL;
        end
    end

endmodule

// File: memSubsystem.sv
module memSubsystem
    import pipePkg::*;
#(
    parameter int RAM_DEPTH_LOG2 = 8,
    parameter int RAM_LATENCY    = 2
) (
    input  logic        clk,
    input  logic        rstN,
    input  ExeMemBundle exeIn,
    input  logic        exeWr,
    input  logic        memFlush,
    output MemWbBundle  wbOut,
    output logic        stall
);

    ExeMemBundle exMemQ;
    MemReq       alignReq;
    MemReq       ramReq;
    MemWbBundle  wbNext;
    logic        misaligned;
    logic        exMemWr;
    logic        exMemFlush;
    logic        start;
    logic        req;
    logic        ack;
    logic [31:0] rdata;
    logic [31:0] loadData;

    assign exMemWr    = exeWr && !stall;
    // stage advancing with nothing new leaves a bubble behind
    assign exMemFlush = memFlush || (!exeWr && !stall);

    assign start = exMemQ.valid && !misaligned &&
                   ((exMemQ.loadType != LD_NONE) || (exMemQ.storeType != ST_NONE));

    pipeReg #(.PAYLOAD_T(ExeMemBundle)) exMem (
        .clk   (clk),
        .rstN  (rstN),
        .flush (exMemFlush),
        .wr    (exMemWr),
        .d     (exeIn),
        .q     (exMemQ)
    );

    storeAlign #(.ADDR_W(RAM_DEPTH_LOG2)) align (
        .ex         (exMemQ),
        .req        (alignReq),
        .misaligned (misaligned)
    );

    dataMemPort #(.ADDR_W(RAM_DEPTH_LOG2)) port (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .newEntry (exMemWr),
        .reqIn    (alignReq),
        .memReq   (ramReq),
        .req      (req),
        .ack      (ack),
        .rdata    (rdata),
        .loadData (loadData),
        .busy     (stall)
    );

    dataRam #(
        .RAM_DEPTH_LOG2 (RAM_DEPTH_LOG2),
        .RAM_LATENCY    (RAM_LATENCY)
    ) ram (
        .clk    (clk),
        .rstN   (rstN),
        .memReq (ramReq),
        .req    (req),
        .ack    (ack),
        .rdata  (rdata)
    );

    loadExtract extract (
        .ex         (exMemQ),
        .loadData   (loadData),
        .misaligned (misaligned),
        .wb         (wbNext)
    );

    // bubbles go to writeback while the access is pending
    pipeReg #(.PAYLOAD_T(MemWbBundle)) memWb (
        .clk   (clk),
        .rstN  (rstN),
        .flush (stall),
        .wr    (1'b1),
        .d     (wbNext),
        .q     (wbOut)
    );

endmodule

// File: tb_memSubsystem.sv
module tb_memSubsystem
    import pipePkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_VEC = 64;

    logic        clk;
    logic        rstN;
    ExeMemBundle exeIn;
    logic        exeWr;
    logic        memFlush;
    MemWbBundle  wbOut;
    logic        stall;

    // vectors as read from the data file
    string       vOp [MAX_VEC];
    logic [31:0] vAddr [MAX_VEC];
    logic [31:0] vData [MAX_VEC];
    int          vFlush [MAX_VEC];
    logic [31:0] vExp [MAX_VEC];
    ExcCode      vExc [MAX_VEC];
    bit          vNoWb [MAX_VEC];
    int          vecCount = 0;
    bit          loaded = 1'b0;

    // writebacks still owed, in program order
    MemWbBundle  expWb [$];
    string       expName [$];
    int          expEdge [$];
    MemWbBundle  gotExp;
    string       gotName;
    int          gotEdge;
    int          edgeCount = 0;

    memSubsystem #(
        .RAM_DEPTH_LOG2 (8),
        .RAM_LATENCY    (2)
    ) uut (
        .clk      (clk),
        .rstN     (rstN),
        .exeIn    (exeIn),
        .exeWr    (exeWr),
        .memFlush (memFlush),
        .wbOut    (wbOut),
        .stall    (stall)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
    end

    task automatic compareValue(input string testName, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR: %s expected %h actual %h", testName, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch in %s", testName);
        end
    endtask

    function automatic bit isStoreOp(input string op);
        return (op == "sb") || (op == "sh") || (op == "sw");
    endfunction

    function automatic logic [31:0] pcOf(input int i);
        return 32'h0040_0000 + 32'(4 * i);
    endfunction

    function automatic logic [4:0] dstOf(input int i);
        return 5'(i % 31 + 1);
    endfunction

    function automatic ExeMemBundle makeBundle(input int i);
        ExeMemBundle b;
        b           = '0;
        b.valid     = 1'b1;
        b.pc        = pcOf(i);
        b.aluOut    = vAddr[i];
        b.storeData = vData[i];
        b.dst       = dstOf(i);
        case (vOp[i])
            "lb":    b.loadType = LD_BS;
            "lbu":   b.loadType = LD_BU;
            "lh":    b.loadType = LD_HS;
            "lhu":   b.loadType = LD_HU;
            "lw":    b.loadType = LD_W;
            "sb":    b.storeType = ST_B;
            "sh":    b.storeType = ST_H;
            "sw":    b.storeType = ST_W;
            default: b.loadType = LD_NONE;
        endcase
        b.wbSel    = (b.loadType != LD_NONE) ? WB_MEM : WB_ALU;
        b.regWrite = (b.storeType == ST_NONE);
        return b;
    endfunction

    task automatic loadVectors();
        int          fd;
        int          n;
        int          c;
        int          flag;
        string       tok;
        string       expTok;
        logic [31:0] addr;
        logic [31:0] data;
        fd = $fopen("memVectors.txt", "r");
        if (fd == 0) begin
            $display("could not open memVectors.txt");
            $display("STATUS: FAIL");
            $fatal(1, "vector file missing");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                // comment runs to end of line
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                n = $fscanf(fd, "%h %h %d %s", addr, data, flag, expTok);
                if (n != 4 || vecCount == MAX_VEC) begin
                    $display("bad or surplus vector line after op %s", tok);
                    $display("STATUS: FAIL");
                    $fatal(1, "vector file unreadable");
                end else begin
                    vOp[vecCount]    = tok;
                    vAddr[vecCount]  = addr;
                    vData[vecCount]  = data;
                    vFlush[vecCount] = flag;
                    vExp[vecCount]   = '0;
                    vExc[vecCount]   = EXC_NONE;
                    vNoWb[vecCount]  = (expTok == "-");
                    if (expTok == "ADEL") begin
                        vExc[vecCount] = EXC_ADEL;
                    end else if (expTok == "ADES") begin
                        vExc[vecCount] = EXC_ADES;
                    end else if (expTok != "-") begin
                        vExp[vecCount] = expTok.atohex();
                    end
                    vecCount++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic queueExpect(input int i, input int accEdge);
        MemWbBundle e;
        bit         isAccess;
        isAccess   = (vOp[i] != "alu") && (vExc[i] == EXC_NONE);
        e          = '0;
        e.valid    = 1'b1;
        e.pc       = pcOf(i);
        e.wbData   = vExp[i];
        e.dst      = dstOf(i);
        e.exc      = vExc[i];
        // stores and address errors leave the register file alone
        e.regWrite = (vExc[i] == EXC_NONE) && !isStoreOp(vOp[i]);
        if (!vNoWb[i]) begin
            expWb.push_back(e);
            expName.push_back($sformatf("vector %0d %s", i, vOp[i]));
            // one edge in EX/MEM, then out of MEM/WB
            expEdge.push_back(isAccess ? -1 : accEdge + 1);
        end
    endtask

    task automatic sendVector(input int i);
        exeIn <= makeBundle(i);
        exeWr <= 1'b1;
        @(posedge clk);
        memFlush <= 1'b0;
        while (stall) begin
            @(posedge clk);
        end
        // taken into EX/MEM at this edge
        queueExpect(i, edgeCount + 1);
        memFlush <= (vFlush[i] != 0);
    endtask

    always @(negedge clk) begin
        if (rstN && wbOut.valid) begin
            if (expName.size() == 0) begin
                $display("writeback from pc %h arrived with none expected", wbOut.pc);
                $display("STATUS: FAIL");
                $fatal(1, "extra writeback");
            end else begin
                gotExp  = expWb.pop_front();
                gotName = expName.pop_front();
                gotEdge = expEdge.pop_front();
                compareValue($sformatf("%s pc", gotName), gotExp.pc, wbOut.pc);
                compareValue($sformatf("%s exc", gotName), 32'(gotExp.exc), 32'(wbOut.exc));
                compareValue($sformatf("%s regWrite", gotName), 32'(gotExp.regWrite),
                             32'(wbOut.regWrite));
                compareValue($sformatf("%s dst", gotName), 32'(gotExp.dst), 32'(wbOut.dst));
                if (gotExp.exc == EXC_NONE) begin
                    compareValue($sformatf("%s wbData", gotName), gotExp.wbData, wbOut.wbData);
                end
                if (gotEdge >= 0) begin
                    compareValue($sformatf("%s edge", gotName), 32'(gotEdge), 32'(edgeCount));
                end
            end
        end
    end

    // budget of 20 cycles per vector
    initial begin
        wait (loaded);
        repeat (vecCount * 20) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", vecCount * 20);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rstN     = 1'b0;
        exeIn    = '0;
        exeWr    = 1'b0;
        memFlush = 1'b0;
        loadVectors();
        if (vecCount == 0) begin
            $display("vector file holds no vectors");
            $display("STATUS: FAIL");
            $fatal(1, "empty vector file");
        end
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        compareValue("reset stall", 32'(0), 32'(stall));
        compareValue("reset req", 32'(0), 32'(uut.req));
        compareValue("reset ack", 32'(0), 32'(uut.ack));
        compareValue("reset wb valid", 32'(0), 32'(wbOut.valid));
        compareValue("reset wb regWrite", 32'(0), 32'(wbOut.regWrite));
        @(posedge clk);
        for (int i = 0; i < vecCount; i++) begin
            sendVector(i);
        end
        exeWr <= 1'b0;
        exeIn <= '0;
        @(posedge clk);
        memFlush <= 1'b0;
        while (expName.size() != 0 || stall) begin
            @(posedge clk);
        end
        // room for any stray writeback to show up
        repeat (4) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: memVectors.txt
# op addr storeData flush expect
# expect is wbData in hex, ADEL or ADES for an address error, - for no writeback
alu 00000010 00000000 0 00000010
alu 12345678 00000000 0 12345678
sw  00000100 a1b2c3d4 0 00000100
lw  00000100 00000000 0 a1b2c3d4
lb  00000100 00000000 0 ffffffd4
lbu 00000101 00000000 0 000000c3
lb  00000102 00000000 0 ffffffb2
lbu 00000103 00000000 0 000000a1
lh  00000100 00000000 0 ffffc3d4
lhu 00000102 00000000 0 0000a1b2
lh  00000102 00000000 0 ffffa1b2
sb  00000105 0000007f 0 00000105
sb  00000106 00000080 0 00000106
lw  00000104 00000000 0 00807f00
lb  00000105 00000000 0 0000007f
lb  00000106 00000000 0 ffffff80
sh  0000010a 0000beef 0 0000010a
sh  00000108 00001234 0 00000108
lhu 0000010a 00000000 0 0000beef
lh  0000010a 00000000 0 ffffbeef
lh  00000108 00000000 0 00001234
lw  00000108 00000000 0 beef1234
alu 00000abc 00000000 0 00000abc
lw  00000102 00000000 0 ADEL
lh  00000101 00000000 0 ADEL
lhu 00000103 00000000 0 ADEL
sw  00000106 deadbeef 0 ADES
sh  00000103 ffffffff 0 ADES
lw  00000104 00000000 0 00807f00
lw  00000100 00000000 0 a1b2c3d4
sw  00000200 cafef00d 1 -
lw  00000200 00000000 0 cafef00d
lw  00000100 00000000 1 -
sb  00000200 00000011 1 -
lw  00000200 00000000 0 cafef011
alu 00000055 00000000 0 00000055
lb  00000203 00000000 0 ffffffca
lhu 00000200 00000000 0 0000f011
alu ffffffff 00000000 0 ffffffff

// File: tb.f
pipePkg.sv
pipeReg.sv
storeAlign.sv
dataMemPort.sv
dataRam.sv
loadExtract.sv
memSubsystem.sv
tb_memSubsystem.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --timescale 1ns/100ps \
    -f tb.f --top-module tb_memSubsystem -o simMem
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/simMem
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
